//--- source/axi_pkg.sv
// ***********************************************
// axi_pkg: widths and response codes of the
// reduced AXI read port used by instruction fetch.
// ***********************************************
package axi_pkg;

  // byte address width of the read port.
  localparam int addr_width = 32;

  // one read beat carries a whole fetch line.
  localparam int data_width = 64;

  localparam int resp_w = 2;

  // anything other than OKAY is treated as a fetch fault.
  localparam logic [resp_w-1:0] resp_okay = 2'b00;

endpackage : axi_pkg

//--- source/fetch_pkg.sv
// ***********************************************
// fetch_pkg: instruction, pc and fetch line types
// shared by the instruction fetch front end.
// ***********************************************
package fetch_pkg;

  typedef logic [31:0] instr_t;

  // bit 0 of a RISC-V pc is always zero, so only halfwords are tracked.
  typedef logic [31:1] pc_t;

  // addi x0, x0, 0.
  localparam instr_t nop_instr = 32'h0000_0013;

  // a fetch line holds four halfwords or two full words.
  typedef union packed {
    logic [3:0][15:0] hw;
    logic [1:0][31:0] word;
  } fetch_line_u;

  // low opcode bits of every 32-bit instruction.
  localparam logic [1:0] full_opcode = 2'b11;

  // a halfword starts a 16-bit instruction unless both low bits are set.
  function automatic logic is_compressed(input logic [15:0] hw);
    return hw[1:0] != full_opcode;
  endfunction

endpackage : fetch_pkg

//--- source/fetch_mem_ctrl.sv
// ***********************************************
// fetch_mem_ctrl: issues sequential line reads on
// the AXI read port and forwards live responses.
// ***********************************************
module fetch_mem_ctrl #(
  parameter int max_outstanding = 2,
  parameter int cnt_w           = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             pc_update,
  input  fetch_pkg::pc_t                   pc_in,
  input  logic                             space,
  output logic [cnt_w-1:0]                 outstanding,
  output logic [axi_pkg::addr_width-1:0]   araddr,
  output logic                             arvalid,
  input  logic                             arready,
  input  logic [axi_pkg::data_width-1:0]   rdata,
  input  logic [axi_pkg::resp_w-1:0]       rresp,
  input  logic                             rvalid,
  output logic                             rready,
  output logic                             push,
  output fetch_pkg::fetch_line_u           push_line,
  output fetch_pkg::pc_t                   push_addr,
  output logic                             push_fault
);

  logic [axi_pkg::addr_width-1:3] next_line;  // line of the next request.
  logic [axi_pkg::addr_width-1:3] resp_line;  // line of the next live response.
  logic [cnt_w-1:0]               discard;
  logic [cnt_w-1:0]               out_next;
  logic                           ar_hs;
  logic                           r_hs;
  logic                           drop;
  logic                           issue;

  // responses are always accepted, the buffer space was reserved at request time.
  assign rready = 1'b1;

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;

  // responses owed from before a redirect are dropped in arrival order.
  assign drop = r_hs && (discard != '0);

  // a beat arriving with the redirect itself still belongs to the old stream.
  assign push = r_hs && (discard == '0) && !pc_update;

  assign push_line  = fetch_pkg::fetch_line_u'(rdata);
  assign push_addr  = {resp_line, 2'b00};
  assign push_fault = rresp != axi_pkg::resp_okay;

  // a new request needs a free credit and room in the in-flight count.
  assign issue = !arvalid && space && !pc_update && (outstanding < max_outstanding);

  assign out_next = outstanding + cnt_w'(ar_hs) - cnt_w'(r_hs);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arvalid     <= 1'b0;
      araddr      <= '0;
      next_line   <= '0;
      resp_line   <= '0;
      outstanding <= '0;
      discard     <= '0;
    end else begin
      outstanding <= out_next;

      // an AR already on the bus is never withdrawn.
      if (ar_hs) begin
        arvalid <= 1'b0;
      end else if (issue) begin
        arvalid <= 1'b1;
      end

      if (pc_update) begin
        next_line <= pc_in[31:3];
        resp_line <= pc_in[31:3];
        // everything in flight, plus a request still waiting for arready, is stale.
        discard   <= out_next + cnt_w'(arvalid && !arready);
      end else begin
        if (drop) begin
          discard <= discard - 1'b1;
        end
        if (push) begin
          resp_line <= resp_line + 1'b1;
        end
        if (issue) begin
          araddr    <= {next_line, 3'b000};
          next_line <= next_line + 1'b1;
        end
      end
    end
  end

endmodule : fetch_mem_ctrl

//--- source/line_buffer.sv
// ***********************************************
// line_buffer: small FIFO of fetched lines with
// their address and fault flag.
// ***********************************************
module line_buffer #(
  parameter int buf_depth = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                pc_update,
  input  logic                                push,
  input  fetch_pkg::fetch_line_u              push_line,
  input  fetch_pkg::pc_t                      push_addr,
  input  logic                                push_fault,
  input  logic                                pop,
  input  logic [$clog2(buf_depth + 1)-1:0]    outstanding,
  output logic                                space,
  output logic                                head_valid,
  output fetch_pkg::fetch_line_u              head_line,
  output fetch_pkg::pc_t                      head_addr,
  output logic                                head_fault
);

  localparam int ptr_w = $clog2(buf_depth);
  localparam int cnt_w = $clog2(buf_depth + 1);

  fetch_pkg::fetch_line_u line_mem [buf_depth];
  fetch_pkg::pc_t         addr_mem [buf_depth];
  logic                   fault_mem[buf_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w:0]   committed;
  logic             do_pop;

  assign head_valid = count != '0;
  assign do_pop     = pop && head_valid;

  assign head_line  = line_mem[rd_ptr];
  assign head_addr  = addr_mem[rd_ptr];
  assign head_fault = fault_mem[rd_ptr];

  // lines already held plus lines still on their way.
  assign committed = {1'b0, count} + {1'b0, outstanding};
  assign space     = committed < buf_depth;

  always_ff @(posedge clk) begin
    if (push) begin
      line_mem[wr_ptr]  <= push_line;
      addr_mem[wr_ptr]  <= push_addr;
      fault_mem[wr_ptr] <= push_fault;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (pc_update) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + cnt_w'(push) - cnt_w'(do_pop);
    end
  end

endmodule : line_buffer

//--- source/instr_aligner.sv
// ***********************************************
// instr_aligner: walks fetch lines by halfword and
// emits one aligned instruction per cycle.
// ***********************************************
module instr_aligner (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_update,
  input  fetch_pkg::pc_t         pc_in,
  input  logic                   stall,
  input  logic                   head_valid,
  input  fetch_pkg::fetch_line_u head_line,
  input  fetch_pkg::pc_t         head_addr,
  input  logic                   head_fault,
  output logic                   pop,
  output fetch_pkg::instr_t      instr,
  output fetch_pkg::pc_t         instr_pc,
  output logic                   comp,
  output logic                   fault,
  output logic                   instr_valid
);

  fetch_pkg::pc_t    pc_q;        // start of the next instruction.
  fetch_pkg::pc_t    cur;         // next halfword to consume.
  logic              held_valid;
  logic [15:0]       held_hw;
  logic              held_fault;
  logic [1:0]        idx;
  logic [1:0]        idx_hi;
  logic [15:0]       hw_lo;
  logic [15:0]       hw_hi;
  logic              line_hit;
  logic              go;
  logic              emit;
  logic              start_span;
  logic [1:0]        step;
  fetch_pkg::instr_t nx_instr;
  logic              nx_comp;
  logic              nx_fault;

  // the low half of a spanning instruction is already held.
  assign cur    = held_valid ? pc_q + 31'd1 : pc_q;
  assign idx    = cur[2:1];
  assign idx_hi = idx + 2'd1;
  assign hw_lo  = head_line.hw[idx];
  assign hw_hi  = head_line.hw[idx_hi];

  assign line_hit = head_addr[31:3] == cur[31:3];
  assign go       = head_valid && !stall && !pc_update;

  always_comb begin
    emit       = 1'b0;
    pop        = 1'b0;
    start_span = 1'b0;
    step       = 2'd0;
    nx_instr   = fetch_pkg::nop_instr;
    nx_comp    = 1'b0;
    nx_fault   = head_fault;
    if (go) begin
      if (!line_hit) begin
        pop = 1'b1;  // left over from an older stream.
      end else if (held_valid) begin
        // upper half sits at index 0 of the new line.
        emit     = 1'b1;
        nx_instr = {hw_lo, held_hw};
        nx_fault = held_fault | head_fault;
        step     = 2'd2;
      end else if (fetch_pkg::is_compressed(hw_lo)) begin
        emit     = 1'b1;
        nx_instr = {16'h0000, hw_lo};
        nx_comp  = 1'b1;
        step     = 2'd1;
        pop      = idx == 2'd3;
      end else if (idx == 2'd3) begin
        start_span = 1'b1;  // 32-bit instruction runs into the next line.
        pop        = 1'b1;
      end else begin
        emit     = 1'b1;
        nx_instr = {hw_hi, hw_lo};
        step     = 2'd2;
        pop      = idx == 2'd2;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= '0;
      held_valid  <= 1'b0;
      instr       <= fetch_pkg::nop_instr;
      instr_pc    <= '0;
      comp        <= 1'b0;
      fault       <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= emit;
      if (pc_update) begin
        pc_q       <= pc_in;
        held_valid <= 1'b0;
        instr      <= fetch_pkg::nop_instr;
        comp       <= 1'b0;
        fault      <= 1'b0;
      end else begin
        if (emit) begin
          instr      <= nx_instr;
          instr_pc   <= pc_q;
          comp       <= nx_comp;
          fault      <= nx_fault;
          pc_q       <= pc_q + 31'(step);
          held_valid <= 1'b0;
        end
        if (start_span) held_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_span) begin
      held_hw    <= hw_lo;
      held_fault <= head_fault;
    end
  end

endmodule : instr_aligner

//--- source/fetch_unit.sv
// ***********************************************
// fetch_unit: instruction fetch front end with
// memory controller, line buffer and aligner.
// ***********************************************
module fetch_unit #(
  parameter int buf_depth       = 2,
  parameter int max_outstanding = 2
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  fetch_pkg::pc_t                 pc_in,
  input  logic                           pc_update,
  input  logic                           stall,
  output fetch_pkg::instr_t              instr,
  output fetch_pkg::pc_t                 instr_pc,
  output logic                           comp,
  output logic                           fault,
  output logic                           instr_valid,
  output logic [axi_pkg::addr_width-1:0] araddr,
  output logic                           arvalid,
  input  logic                           arready,
  input  logic [axi_pkg::data_width-1:0] rdata,
  input  logic [axi_pkg::resp_w-1:0]     rresp,
  input  logic                           rlast,
  input  logic                           rvalid,
  output logic                           rready
);

  localparam int cnt_w = $clog2(buf_depth + 1);

  logic                   space;
  logic [cnt_w-1:0]       outstanding;
  logic                   beat_valid;
  logic                   push;
  fetch_pkg::fetch_line_u push_line;
  fetch_pkg::pc_t         push_addr;
  logic                   push_fault;
  logic                   pop;
  logic                   head_valid;
  fetch_pkg::fetch_line_u head_line;
  fetch_pkg::pc_t         head_addr;
  logic                   head_fault;

  // every read is one beat, so a beat completes its read only when it is the last.
  assign beat_valid = rvalid & rlast;

  fetch_mem_ctrl #(
    .max_outstanding(max_outstanding),
    .cnt_w          (cnt_w)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_update  (pc_update),
    .pc_in      (pc_in),
    .space      (space),
    .outstanding(outstanding),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (beat_valid),
    .rready     (rready),
    .push       (push),
    .push_line  (push_line),
    .push_addr  (push_addr),
    .push_fault (push_fault)
  );

  line_buffer #(
    .buf_depth(buf_depth)
  ) u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_update  (pc_update),
    .push       (push),
    .push_line  (push_line),
    .push_addr  (push_addr),
    .push_fault (push_fault),
    .pop        (pop),
    .outstanding(outstanding),
    .space      (space),
    .head_valid (head_valid),
    .head_line  (head_line),
    .head_addr  (head_addr),
    .head_fault (head_fault)
  );

  instr_aligner u_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_update  (pc_update),
    .pc_in      (pc_in),
    .stall      (stall),
    .head_valid (head_valid),
    .head_line  (head_line),
    .head_addr  (head_addr),
    .head_fault (head_fault),
    .pop        (pop),
    .instr      (instr),
    .instr_pc   (instr_pc),
    .comp       (comp),
    .fault      (fault),
    .instr_valid(instr_valid)
  );

endmodule : fetch_unit

//--- dv/fetch_chk.sv
// **************************************************
// fetch_chk: protocol and reset checks on the ports
// of the fetch unit.
// **************************************************
module fetch_chk (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           pc_update,
  input logic                           arvalid,
  input logic                           arready,
  input logic [axi_pkg::addr_width-1:0] araddr,
  input logic                           instr_valid,
  input fetch_pkg::instr_t              instr
);

  // a pending AR keeps its address until arready.
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("AR request changed or dropped before arready");

  no_valid_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    pc_update |=> !instr_valid)
    else $error("instruction emitted in the cycle after a redirect");

  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !arvalid && !instr_valid && instr == fetch_pkg::nop_instr)
    else $error("outputs not idle when reset was released");

endmodule : fetch_chk

bind fetch_unit fetch_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .pc_update  (pc_update),
  .arvalid    (arvalid),
  .arready    (arready),
  .araddr     (araddr),
  .instr_valid(instr_valid),
  .instr      (instr)
);

//--- dv/fetch_tb.sv
// **************************************************
// fetch_tb: runs the fetch unit on a random program
// image and checks every emitted instruction.
// **************************************************
module fetch_tb;

  logic                           clk;
  logic                           rst_n;
  fetch_pkg::pc_t                 pc_in;
  logic                           pc_update;
  logic                           stall;
  fetch_pkg::instr_t              instr;
  fetch_pkg::pc_t                 instr_pc;
  logic                           comp;
  logic                           fault;
  logic                           instr_valid;
  logic [axi_pkg::addr_width-1:0] araddr;
  logic                           arvalid;
  logic                           arready;
  logic [axi_pkg::data_width-1:0] rdata;
  logic [axi_pkg::resp_w-1:0]     rresp;
  logic                           rlast;
  logic                           rvalid;
  logic                           rready;

  fetch_pkg::fetch_line_u mem [64];  // program image, wraps every 512 bytes.
  logic                   fault_line [64];
  logic [5:0]             req_line [$];
  int                     req_due [$];
  int                     cyc = 0;
  int                     seed = 32'hbb7d0787;
  int                     n_checked = 0;
  int                     n_faults = 0;
  int                     n_wide = 0;
  fetch_pkg::pc_t         exp_pc = '0;
  fetch_pkg::pc_t         next_pc;
  fetch_pkg::instr_t      exp_instr;
  logic                   exp_comp;
  logic                   exp_fault;
  logic                   stall_q = 1'b0;
  logic                   upd_q = 1'b0;
  fetch_pkg::instr_t      last_instr;
  fetch_pkg::pc_t         last_pc;
  logic                   last_comp;
  logic                   last_fault;

  fetch_unit #(
    .buf_depth      (2),
    .max_outstanding(2)
  ) DUT (
    .clk(clk), .rst_n(rst_n), .pc_in(pc_in), .pc_update(pc_update), .stall(stall),
    .instr(instr), .instr_pc(instr_pc), .comp(comp), .fault(fault),
    .instr_valid(instr_valid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_t got,
                             input fetch_pkg::instr_t exp);
    if (got !== exp)
      stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_pc(input string name, input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp);
    if (got !== exp)
      stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // a random stream of 16-bit and 32-bit instructions whose last slot is always short.
  task automatic build_program();
    logic [15:0] hw_img [256];
    logic [31:0] r;
    int          h;
    h = 0;
    while (h < 256) begin
      r = $random(seed);
      if (r[4] || h == 255) begin
        hw_img[h] = {r[31:18], (r[1:0] == 2'b11) ? 2'b01 : r[1:0]};
        h = h + 1;
      end else begin
        hw_img[h]     = {r[31:18], 2'b11};
        hw_img[h + 1] = r[17:2];
        h = h + 2;
      end
    end
    for (int l = 0; l < 64; l++) begin
      mem[l].word[0] = {hw_img[4 * l + 1], hw_img[4 * l]};
      mem[l].word[1] = {hw_img[4 * l + 3], hw_img[4 * l + 2]};
      fault_line[l]  = (l == 1) || (({$random(seed)} % 8) == 0);
    end
  endtask

  function automatic logic [15:0] halfword_at(input fetch_pkg::pc_t pc);
    logic [31:0] w;
    w = mem[pc[8:3]].word[pc[2]];
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  // expected instruction at pc, with its compressed and fault flags and the next pc.
  function automatic fetch_pkg::instr_t expect_instr(input fetch_pkg::pc_t pc, output logic c,
                                                     output logic f, output fetch_pkg::pc_t nxt);
    logic [15:0]    lo;
    logic [15:0]    hi;
    fetch_pkg::pc_t pc_hi;
    pc_hi = pc + 31'd1;
    lo    = halfword_at(pc);
    hi    = halfword_at(pc_hi);
    c     = lo[1:0] != 2'b11;
    f     = fault_line[pc[8:3]] | (!c && fault_line[pc_hi[8:3]]);
    nxt   = c ? pc_hi : pc + 31'd2;
    return c ? {16'h0000, lo} : {hi, lo};
  endfunction

  // AXI slave with random arready and a 1 to 6 cycle read latency.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (rvalid && rready) begin
        void'(req_line.pop_front());
        void'(req_due.pop_front());
      end
      if (arvalid && arready) begin
        req_line.push_back(araddr[8:3]);
        req_due.push_back(cyc + ({$random(seed)} % 6));
      end
      arready <= ($random(seed) & 3) != 0;
      if (req_line.size() > 0 && req_due[0] <= cyc) begin
        rvalid <= 1'b1;
        rdata  <= mem[req_line[0]];
        rresp  <= fault_line[req_line[0]] ? 2'b10 : axi_pkg::resp_okay;
      end else begin
        rvalid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // a stall seen at the last edge freezes everything but a redirect.
      if (stall_q && !upd_q) begin
        check_flag("instr_valid", instr_valid, 1'b0);
        check_instr("instr", instr, last_instr);
        check_pc("instr_pc", instr_pc, last_pc);
        check_flag("comp", comp, last_comp);
        check_flag("fault", fault, last_fault);
      end
      if (instr_valid) begin
        exp_instr = expect_instr(exp_pc, exp_comp, exp_fault, next_pc);
        check_pc("instr_pc", instr_pc, exp_pc);
        check_instr("instr", instr, exp_instr);
        check_flag("comp", comp, exp_comp);
        check_flag("fault", fault, exp_fault);
        n_checked = n_checked + 1;
        if (exp_fault) n_faults = n_faults + 1;
        if (!exp_comp) n_wide = n_wide + 1;
        exp_pc = next_pc;
      end
      if (pc_update) exp_pc = pc_in;
    end
    stall_q    = stall;
    upd_q      = pc_update;
    last_instr = instr;
    last_pc    = instr_pc;
    last_comp  = comp;
    last_fault = fault;
  end

  task automatic wait_instrs(input int target, input bit random_stall);
    int cycles;
    cycles = 0;
    while (n_checked < target) begin
      @(posedge clk);
      stall  <= random_stall && (({$random(seed)} % 4) == 0);
      cycles = cycles + 1;
      if (cycles > 5000) stop_run("timeout while waiting for instructions from the DUT");
    end
  endtask

  // walks the program from pc 0 so the target is a real instruction start.
  function automatic fetch_pkg::pc_t pick_target(input bit want_odd);
    fetch_pkg::pc_t pc;
    fetch_pkg::pc_t nxt;
    logic           c;
    logic           f;
    int             steps;
    pc    = '0;
    steps = 20 + ({$random(seed)} % 200);
    for (int i = 0; i < steps || (want_odd && !pc[1] && i < steps + 256); i++) begin
      void'(expect_instr(pc, c, f, nxt));
      pc = nxt;
    end
    return pc;
  endfunction

  task automatic redirect(input fetch_pkg::pc_t target);
    @(posedge clk);
    pc_in     <= target;
    pc_update <= 1'b1;
    @(posedge clk);
    pc_update <= 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    pc_in     = '0;
    pc_update = 1'b0;
    stall     = 1'b0;
    arready   = 1'b0;
    rdata     = '0;
    rresp     = '0;
    rlast     = 1'b1;
    rvalid    = 1'b0;
    build_program();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    wait_instrs(60, 1'b0);
    for (int i = 0; i < 6; i++) begin
      redirect(pick_target(i == 0));
      wait_instrs(n_checked + 15, 1'b0);
    end

    wait_instrs(n_checked + 120, 1'b1);
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      stall <= 1'b1;  // long enough to fill the buffer.
    end
    for (int i = 0; i < 4; i++) begin
      redirect(pick_target(i[0]));
      wait_instrs(n_checked + 25, 1'b1);
    end

    if (n_faults == 0 || n_wide == 0) begin
      stop_run("the run never produced a faulted or a 32-bit instruction");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule : fetch_tb

//--- flist.f
source/axi_pkg.sv
source/fetch_pkg.sv
source/fetch_mem_ctrl.sv
source/line_buffer.sv
source/instr_aligner.sv
source/fetch_unit.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

//--- Makefile
# Verilator build for the instruction fetch front end.

TOP = fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -o fetch_sim
	./obj_dir/fetch_sim

clean:
	rm -rf obj_dir
